// File: common/instr_pkg.sv
// instruction level types
// functional units, register indices and data words seen by decode and execute

`include "sb_params.svh"

package instr_pkg;

  // ----------------------------------------------------------------------
  // functional units
  // ----------------------------------------------------------------------
  // NONE has no write-back and completes on its own
  typedef enum logic [2:0] {
    NONE   = 3'd0,
    ALU    = 3'd1,
    BRANCH = 3'd2,
    LOAD   = 3'd3,
    STORE  = 3'd4,
    MULT   = 3'd5
  } fu_t;

  // ----------------------------------------------------------------------
  // operand types
  // ----------------------------------------------------------------------
  // architectural register index
  typedef logic [`SB_REG_ADDR_W-1:0] reg_addr_t;

  // integer data word
  typedef logic [`SB_XLEN-1:0] xlen_t;

endpackage

// File: common/sb_params.svh
// scoreboard sizing parameters
// queue depth, write-back port count and datapath widths

`ifndef SB_PARAMS_SVH
`define SB_PARAMS_SVH

// queue depth, must stay a power of two for the full flag
`define SB_NR_ENTRIES 8

// number of functional unit write-back ports
`define SB_NR_WB_PORTS 2

// integer data word width
`define SB_XLEN 32

// register index width, 32 architectural registers
`define SB_REG_ADDR_W 5

`endif

// File: common/sb_pkg.sv
// scoreboard level types
// transaction ids, occupancy count and the stored slot record

`include "sb_params.svh"

package sb_pkg;

  import instr_pkg::*;

  // slot index bits, also the transaction id width
  localparam int unsigned TRANS_ID_W = $clog2(`SB_NR_ENTRIES);

  typedef logic [TRANS_ID_W-1:0] trans_id_t;

  // one extra bit so a full queue is distinguishable from an empty one
  typedef logic [TRANS_ID_W:0] sb_cnt_t;

  // one queue slot as seen by clobber, forwarding and commit
  typedef struct packed {
    logic      issued;
    logic      done;
    fu_t       fu;
    reg_addr_t rd;
    xlen_t     result;
  } sb_slot_t;

endpackage

// File: hw/scoreboard/sb_clobber.sv
// destination register clobber report
// functional unit of the pending writer for each register

`timescale 1ns/1ps
`include "sb_params.svh"

module sb_clobber (
  input  sb_pkg::sb_slot_t [`SB_NR_ENTRIES-1:0]       slots_i,
  output instr_pkg::fu_t   [2**`SB_REG_ADDR_W-1:0]    rd_clobber_o
);

  import instr_pkg::*;

  // ----------------------------------------------------------------------
  // per-register owner search
  // ----------------------------------------------------------------------
  always_comb begin
    // default is no pending writer
    for (int r = 0; r < 2**`SB_REG_ADDR_W; r++) begin
      rd_clobber_o[r] = NONE;
    end

    // walk down so the lowest slot index is written last and wins
    for (int i = `SB_NR_ENTRIES - 1; i >= 0; i--) begin
      if (slots_i[i].issued) begin
        rd_clobber_o[slots_i[i].rd] = slots_i[i].fu;
      end
    end

    // x0 is hardwired and never pending
    rd_clobber_o[0] = NONE;
  end

endmodule

// File: hw/scoreboard/sb_entry_mem.sv
// scoreboard slot storage
// issue write, unit-less completion, write-back by transaction id,
// commit clear and flush of the per-slot flags

`timescale 1ns/1ps
`include "sb_params.svh"

module sb_entry_mem (
  input  logic                                            clk_i,
  input  logic                                            rst_ni,
  input  logic                                            flush_i,
  input  logic                                            issue_en_i,
  input  logic                                            commit_ack_i,
  input  sb_pkg::trans_id_t                               issue_ptr_i,
  input  sb_pkg::trans_id_t                               commit_ptr_i,
  input  instr_pkg::fu_t                                  decoded_fu_i,
  input  instr_pkg::reg_addr_t                            decoded_rd_i,
  input  logic              [`SB_NR_WB_PORTS-1:0]         wb_valid_i,
  input  sb_pkg::trans_id_t [`SB_NR_WB_PORTS-1:0]         wb_trans_id_i,
  input  instr_pkg::xlen_t  [`SB_NR_WB_PORTS-1:0]         wb_data_i,
  output sb_pkg::sb_slot_t  [`SB_NR_ENTRIES-1:0]          slots_o
);

  import instr_pkg::*;

  // control flags
  logic [`SB_NR_ENTRIES-1:0] issued_q, issued_n;
  logic [`SB_NR_ENTRIES-1:0] done_q, done_n;

  // payload
  fu_t       [`SB_NR_ENTRIES-1:0] fu_q;
  reg_addr_t [`SB_NR_ENTRIES-1:0] rd_q;
  xlen_t     [`SB_NR_ENTRIES-1:0] result_q;

  // ----------------------------------------------------------------------
  // flag update
  // ----------------------------------------------------------------------
  always_comb begin
    issued_n = issued_q;
    done_n   = done_q;

    // new entry at the issue pointer, result not yet present
    if (issue_en_i) begin
      issued_n[issue_ptr_i] = 1'b1;
      done_n[issue_ptr_i]   = 1'b0;
    end

    // no functional unit means nothing to wait for
    for (int i = 0; i < `SB_NR_ENTRIES; i++) begin
      if (issued_q[i] && fu_q[i] == NONE) begin
        done_n[i] = 1'b1;
      end
    end

    // write-back only lands on slots still in flight
    for (int p = 0; p < `SB_NR_WB_PORTS; p++) begin
      if (wb_valid_i[p] && issued_q[wb_trans_id_i[p]]) begin
        done_n[wb_trans_id_i[p]] = 1'b1;
      end
    end

    // retire the head slot
    if (commit_ack_i) begin
      issued_n[commit_ptr_i] = 1'b0;
      done_n[commit_ptr_i]   = 1'b0;
    end

    // flush wins over every other update
    if (flush_i) begin
      issued_n = '0;
      done_n   = '0;
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      issued_q <= '0;
      done_q   <= '0;
    end else begin
      issued_q <= issued_n;
      done_q   <= done_n;
    end
  end

  // ----------------------------------------------------------------------
  // payload write
  // ----------------------------------------------------------------------
  always_ff @(posedge clk_i) begin
    if (issue_en_i) begin
      fu_q[issue_ptr_i] <= decoded_fu_i;
      rd_q[issue_ptr_i] <= decoded_rd_i;
    end
    // result stored with the same rule as the done flag
    for (int p = 0; p < `SB_NR_WB_PORTS; p++) begin
      if (wb_valid_i[p] && issued_q[wb_trans_id_i[p]]) begin
        result_q[wb_trans_id_i[p]] <= wb_data_i[p];
      end
    end
  end

  // slot records for clobber, forwarding and commit
  always_comb begin
    for (int i = 0; i < `SB_NR_ENTRIES; i++) begin
      slots_o[i].issued = issued_q[i];
      slots_o[i].done   = done_q[i];
      slots_o[i].fu     = fu_q[i];
      slots_o[i].rd     = rd_q[i];
      slots_o[i].result = result_q[i];
    end
  end

  // units never retire onto the same transaction id in one cycle
  for (genvar i = 0; i < `SB_NR_WB_PORTS; i++) begin : g_wb_a
    for (genvar j = i + 1; j < `SB_NR_WB_PORTS; j++) begin : g_wb_b
      wb_id_unique: assert property (
        @(posedge clk_i) disable iff (!rst_ni)
        wb_valid_i[i] && wb_valid_i[j] |-> wb_trans_id_i[i] != wb_trans_id_i[j])
        else $error("two write-back ports share a transaction id");
    end
  end

  // commit stage only retires a completed head
  commit_head_done: assert property (
    @(posedge clk_i) disable iff (!rst_ni) commit_ack_i |-> done_q[commit_ptr_i])
    else $error("commit acknowledged on an incomplete slot");

endmodule

// File: hw/scoreboard/sb_operand_fwd.sv
// operand forwarding for two source registers
// fixed priority: write-back port 0, port 1, then stored results by slot index

`timescale 1ns/1ps
`include "sb_params.svh"

module sb_operand_fwd (
  input  sb_pkg::sb_slot_t  [`SB_NR_ENTRIES-1:0]   slots_i,
  input  logic              [`SB_NR_WB_PORTS-1:0]  wb_valid_i,
  input  sb_pkg::trans_id_t [`SB_NR_WB_PORTS-1:0]  wb_trans_id_i,
  input  instr_pkg::xlen_t  [`SB_NR_WB_PORTS-1:0]  wb_data_i,
  input  instr_pkg::reg_addr_t                     rs1_addr_i,
  input  instr_pkg::reg_addr_t                     rs2_addr_i,
  output instr_pkg::xlen_t                         rs1_data_o,
  output instr_pkg::xlen_t                         rs2_data_o,
  output logic                                     rs1_valid_o,
  output logic                                     rs2_valid_o
);

  import instr_pkg::*;

  // one source lookup, first hit in priority order is kept
  function automatic void fwd_lookup(input reg_addr_t addr, output xlen_t data,
                                     output logic valid);
    logic hit;
    hit  = 1'b0;
    data = '0;
    // results on the write-back ports in this very cycle
    for (int p = 0; p < `SB_NR_WB_PORTS; p++) begin
      if (!hit && wb_valid_i[p] && slots_i[wb_trans_id_i[p]].issued &&
          slots_i[wb_trans_id_i[p]].rd == addr) begin
        hit  = 1'b1;
        data = wb_data_i[p];
      end
    end
    // results already held in the queue
    for (int i = 0; i < `SB_NR_ENTRIES; i++) begin
      if (!hit && slots_i[i].issued && slots_i[i].done && slots_i[i].rd == addr) begin
        hit  = 1'b1;
        data = slots_i[i].result;
      end
    end
    // x0 reads from the register file
    valid = hit && (addr != '0);
  endfunction

  always_comb begin
    fwd_lookup(rs1_addr_i, rs1_data_o, rs1_valid_o);
    fwd_lookup(rs2_addr_i, rs2_data_o, rs2_valid_o);
  end

endmodule

// File: hw/scoreboard/sb_pointers.sv
// scoreboard queue pointers
// issue pointer, commit pointer and occupancy count with the full flag

`timescale 1ns/1ps
`include "sb_params.svh"

module sb_pointers (
  input  logic              clk_i,
  input  logic              rst_ni,
  input  logic              flush_i,
  input  logic              issue_en_i,
  input  logic              commit_ack_i,
  output sb_pkg::trans_id_t issue_ptr_o,
  output sb_pkg::trans_id_t commit_ptr_o,
  output logic              full_o
);

  import sb_pkg::*;

  trans_id_t issue_ptr_q;
  trans_id_t commit_ptr_q;
  sb_cnt_t   cnt_q;

  // pointers wrap naturally at the queue depth
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      issue_ptr_q  <= '0;
      commit_ptr_q <= '0;
      cnt_q        <= '0;
    end else if (flush_i) begin
      // flush empties the queue
      issue_ptr_q  <= '0;
      commit_ptr_q <= '0;
      cnt_q        <= '0;
    end else begin
      issue_ptr_q  <= issue_ptr_q + trans_id_t'(issue_en_i);
      commit_ptr_q <= commit_ptr_q + trans_id_t'(commit_ack_i);
      // count up on issue, down on commit
      cnt_q        <= cnt_q + sb_cnt_t'(issue_en_i) - sb_cnt_t'(commit_ack_i);
    end
  end

  assign issue_ptr_o  = issue_ptr_q;
  assign commit_ptr_o = commit_ptr_q;

  // top bit set means depth reached, depth is a power of two
  assign full_o = cnt_q[$bits(sb_cnt_t)-1];

  // occupancy stays within the queue depth across issue and commit
  cnt_in_range: assert property (
    @(posedge clk_i) disable iff (!rst_ni) cnt_q <= sb_cnt_t'(`SB_NR_ENTRIES))
    else $error("scoreboard occupancy above queue depth");

endmodule

// File: hw/scoreboard/scoreboard_top.sv
// instruction scoreboard
// in-order issue and commit over an 8-slot circular queue with
// out-of-order write-back, clobber report and operand forwarding

`timescale 1ns/1ps
`include "sb_params.svh"

module scoreboard_top (
  input  logic                                            clk_i,
  input  logic                                            rst_ni,
  input  logic                                            flush_i,
  input  logic                                            flush_unissued_i,
  input  logic                                            unresolved_branch_i,
  input  logic                                            decoded_valid_i,
  input  instr_pkg::fu_t                                  decoded_fu_i,
  input  instr_pkg::reg_addr_t                            decoded_rd_i,
  output logic                                            decoded_ack_o,
  output logic                                            issue_valid_o,
  output sb_pkg::trans_id_t                               issue_trans_id_o,
  input  logic                                            issue_ack_i,
  input  logic              [`SB_NR_WB_PORTS-1:0]         wb_valid_i,
  input  sb_pkg::trans_id_t [`SB_NR_WB_PORTS-1:0]         wb_trans_id_i,
  input  instr_pkg::xlen_t  [`SB_NR_WB_PORTS-1:0]         wb_data_i,
  output logic                                            commit_valid_o,
  output instr_pkg::fu_t                                  commit_fu_o,
  output instr_pkg::reg_addr_t                            commit_rd_o,
  output instr_pkg::xlen_t                                commit_result_o,
  output sb_pkg::trans_id_t                               commit_trans_id_o,
  input  logic                                            commit_ack_i,
  input  instr_pkg::reg_addr_t                            rs1_addr_i,
  output instr_pkg::xlen_t                                rs1_data_o,
  output logic                                            rs1_valid_o,
  input  instr_pkg::reg_addr_t                            rs2_addr_i,
  output instr_pkg::xlen_t                                rs2_data_o,
  output logic                                            rs2_valid_o,
  output instr_pkg::fu_t    [2**`SB_REG_ADDR_W-1:0]       rd_clobber_o,
  output logic                                            sb_full_o
);

  import sb_pkg::*;

  trans_id_t                      issue_ptr;
  trans_id_t                      commit_ptr;
  logic                           full;
  logic                           issue_en;
  sb_slot_t [`SB_NR_ENTRIES-1:0]  slots;

  // ----------------------------------------------------------------------
  // issue gating
  // ----------------------------------------------------------------------
  // hold issue behind an unresolved branch or a full queue
  assign issue_valid_o    = decoded_valid_i & ~unresolved_branch_i & ~full;
  assign decoded_ack_o    = issue_ack_i & ~full;
  assign issue_trans_id_o = issue_ptr;
  // entry write, suppressed while unissued work is flushed
  assign issue_en         = decoded_valid_i & decoded_ack_o & ~flush_unissued_i;
  assign sb_full_o        = full;

  sb_pointers u_pointers (
    .clk_i        (clk_i),
    .rst_ni       (rst_ni),
    .flush_i      (flush_i),
    .issue_en_i   (issue_en),
    .commit_ack_i (commit_ack_i),
    .issue_ptr_o  (issue_ptr),
    .commit_ptr_o (commit_ptr),
    .full_o       (full)
  );

  sb_entry_mem u_entry_mem (
    .clk_i         (clk_i),
    .rst_ni        (rst_ni),
    .flush_i       (flush_i),
    .issue_en_i    (issue_en),
    .commit_ack_i  (commit_ack_i),
    .issue_ptr_i   (issue_ptr),
    .commit_ptr_i  (commit_ptr),
    .decoded_fu_i  (decoded_fu_i),
    .decoded_rd_i  (decoded_rd_i),
    .wb_valid_i    (wb_valid_i),
    .wb_trans_id_i (wb_trans_id_i),
    .wb_data_i     (wb_data_i),
    .slots_o       (slots)
  );

  sb_clobber u_clobber (
    .slots_i      (slots),
    .rd_clobber_o (rd_clobber_o)
  );

  sb_operand_fwd u_operand_fwd (
    .slots_i       (slots),
    .wb_valid_i    (wb_valid_i),
    .wb_trans_id_i (wb_trans_id_i),
    .wb_data_i     (wb_data_i),
    .rs1_addr_i    (rs1_addr_i),
    .rs2_addr_i    (rs2_addr_i),
    .rs1_data_o    (rs1_data_o),
    .rs2_data_o    (rs2_data_o),
    .rs1_valid_o   (rs1_valid_o),
    .rs2_valid_o   (rs2_valid_o)
  );

  // ----------------------------------------------------------------------
  // commit port
  // ----------------------------------------------------------------------
  // head slot presented directly, valid once its result is present
  assign commit_valid_o    = slots[commit_ptr].done;
  assign commit_fu_o       = slots[commit_ptr].fu;
  assign commit_rd_o       = slots[commit_ptr].rd;
  assign commit_result_o   = slots[commit_ptr].result;
  assign commit_trans_id_o = commit_ptr;

  // issue stage never acknowledges an instruction that was not offered
  issue_ack_offered: assert property (
    @(posedge clk_i) disable iff (!rst_ni) issue_ack_i |-> issue_valid_o)
    else $error("issue acknowledged without a valid instruction");

endmodule

// File: project.f
+incdir+common
common/instr_pkg.sv
common/sb_pkg.sv
hw/scoreboard/sb_pointers.sv
hw/scoreboard/sb_entry_mem.sv
hw/scoreboard/sb_clobber.sv
hw/scoreboard/sb_operand_fwd.sv
hw/scoreboard/scoreboard_top.sv
tb/tb_scoreboard.sv

// File: tb/sb_stim.txt
# ISSUE fu rd ack | WB port tid data | COMMIT rd result | READ rs valid data | CLOB reg fu
# FULL v | CVALID v | FLUSH | BRANCH | KILL | IDLE ends a cycle; fu 0..5 none alu br ld st mul
# in-order commit of out-of-order write-backs
CVALID 0
ISSUE 1 1 1
IDLE
ISSUE 1 2 1
IDLE
ISSUE 1 4 1
IDLE
WB 0 2 00000022
WB 1 1 00000011
CVALID 0
IDLE
CVALID 0
WB 0 0 00000010
IDLE
CVALID 1
COMMIT 1 00000010
IDLE
COMMIT 2 00000011
IDLE
COMMIT 4 00000022
IDLE
CVALID 0
# unit-less completion and full queue
ISSUE 0 10 1
IDLE
ISSUE 0 11 1
IDLE
ISSUE 0 12 1
IDLE
ISSUE 0 13 1
IDLE
ISSUE 0 14 1
IDLE
ISSUE 0 15 1
IDLE
ISSUE 0 16 1
IDLE
FULL 0
ISSUE 0 17 1
IDLE
FULL 1
ISSUE 1 9 0
IDLE
FULL 1
COMMIT 10 00000000
IDLE
FULL 0
COMMIT 11 00000000
IDLE
COMMIT 12 00000000
IDLE
FLUSH
IDLE
FULL 0
CVALID 0
# clobber report
ISSUE 1 3 1
IDLE
ISSUE 3 7 1
IDLE
ISSUE 5 0 1
IDLE
CLOB 3 1
CLOB 7 3
CLOB 4 0
CLOB 0 0
WB 0 0 00000333
WB 1 1 00000777
IDLE
CLOB 3 1
WB 0 2 00000999
IDLE
COMMIT 3 00000333
IDLE
COMMIT 7 00000777
IDLE
COMMIT 0 00000999
IDLE
CLOB 3 0
CLOB 7 0
# forwarding priority
ISSUE 1 5 1
IDLE
ISSUE 3 5 1
IDLE
ISSUE 5 5 1
IDLE
WB 0 3 00000055
IDLE
READ 5 1 00000055
READ 6 0 00000000
WB 1 4 00000066
READ 5 1 00000066
IDLE
READ 5 1 00000055
WB 0 5 000000aa
WB 1 4 000000bb
READ 5 1 000000aa
IDLE
CLOB 5 1
ISSUE 1 0 1
IDLE
WB 0 6 00000abc
READ 0 0 00000000
IDLE
READ 0 0 00000000
# flush of unissued and of the whole queue
KILL
ISSUE 2 9 1
IDLE
CLOB 9 0
ISSUE 2 9 1
IDLE
CLOB 9 2
CVALID 1
FLUSH
IDLE
CLOB 9 0
CLOB 5 0
CVALID 0
FULL 0
WB 0 0 00000123
IDLE
CVALID 0
ISSUE 1 8 1
IDLE
CVALID 0
CLOB 8 1
WB 0 0 00000888
READ 8 1 00000888
IDLE
COMMIT 8 00000888
IDLE
# branch gating
BRANCH
ISSUE 4 12 0
IDLE
CLOB 12 0
ISSUE 4 12 1
IDLE
CLOB 12 4
IDLE

// File: tb/tb_scoreboard.sv
// scoreboard testbench
// runs the command script against the scoreboard and checks issue, commit,
// clobber and forwarding responses against a small reference model

`timescale 1ns/1ps
`include "sb_params.svh"

module tb_scoreboard;

  import instr_pkg::*;
  import sb_pkg::*;

  localparam int unsigned CLK_PERIOD = 20;
  localparam int unsigned NR_REGS    = 2**`SB_REG_ADDR_W;

  logic                              clk_i;
  logic                              rst_ni;
  logic                              flush_i;
  logic                              flush_unissued_i;
  logic                              unresolved_branch_i;
  logic                              decoded_valid_i;
  fu_t                               decoded_fu_i;
  reg_addr_t                         decoded_rd_i;
  logic                              decoded_ack_o;
  logic                              issue_valid_o;
  trans_id_t                         issue_trans_id_o;
  logic                              issue_ack_i;
  logic      [`SB_NR_WB_PORTS-1:0]   wb_valid_i;
  trans_id_t [`SB_NR_WB_PORTS-1:0]   wb_trans_id_i;
  xlen_t     [`SB_NR_WB_PORTS-1:0]   wb_data_i;
  logic                              commit_valid_o;
  fu_t                               commit_fu_o;
  reg_addr_t                         commit_rd_o;
  xlen_t                             commit_result_o;
  trans_id_t                         commit_trans_id_o;
  logic                              commit_ack_i;
  reg_addr_t                         rs1_addr_i;
  reg_addr_t                         rs2_addr_i;
  xlen_t                             rs1_data_o;
  xlen_t                             rs2_data_o;
  logic                              rs1_valid_o;
  logic                              rs2_valid_o;
  fu_t       [NR_REGS-1:0]           rd_clobber_o;
  logic                              sb_full_o;

  // script lines, then the reference pointers, occupancy and unit per slot
  string lines_q[$];
  int    num_cmds;
  int    next_tid;
  int    head_tid;
  int    in_flight;
  fu_t   slot_fu [`SB_NR_ENTRIES];

  scoreboard_top dut_i (.*);

  always #(CLK_PERIOD / 2) clk_i = ~clk_i;

  // ----------------------------------------------------------------------
  // helpers
  // ----------------------------------------------------------------------
  task automatic abort_run(input string why);
    $display("%s", why);
    $display("Verification failed");
    $fatal(1, "run stopped");
  endtask

  task automatic check_value(input string name, input logic [31:0] expected,
                             input logic [31:0] actual);
    if (actual !== expected) begin
      abort_run($sformatf("CHECK FAILED %s expected %h actual %h",
                          name, expected, actual));
    end
  endtask

  // single-cycle controls fall back to idle
  task automatic clear_pulses();
    flush_i             = 1'b0;
    flush_unissued_i    = 1'b0;
    unresolved_branch_i = 1'b0;
    decoded_valid_i     = 1'b0;
    decoded_fu_i        = NONE;
    decoded_rd_i        = '0;
    issue_ack_i         = 1'b0;
    wb_valid_i          = '0;
    wb_trans_id_i       = '0;
    wb_data_i           = '0;
    commit_ack_i        = 1'b0;
  endtask

  // advance one cycle and change inputs 2 ns after the edge
  task automatic step_cycle();
    @(posedge clk_i);
    #2;
    clear_pulses();
  endtask

  task automatic load_script();
    int    fd;
    string line;
    string kw;
    fd = $fopen("tb/sb_stim.txt", "r");
    if (fd == 0) begin
      abort_run("cannot open the stimulus file tb/sb_stim.txt");
    end
    while (!$feof(fd)) begin
      line = "";
      if ($fgets(line, fd) != 0) begin
        // blank lines and # lines carry no command
        if ($sscanf(line, "%s", kw) == 1 && kw.getc(0) != "#") begin
          lines_q.push_back(line);
        end
      end
    end
    $fclose(fd);
  endtask

  // ----------------------------------------------------------------------
  // command decoder
  // ----------------------------------------------------------------------
  task automatic run_command(input int idx, input string line);
    string       kw;
    string       name;
    int          a;
    int          b;
    logic [31:0] d;
    void'($sscanf(line, "%s", kw));
    name = $sformatf("cmd %0d %s", idx, kw);
    case (kw)
      "ISSUE": begin
        void'($sscanf(line, "%s %d %d %d", kw, a, b, d));
        decoded_valid_i = 1'b1;
        decoded_fu_i    = fu_t'(a);
        decoded_rd_i    = reg_addr_t'(b);
        #1;
        check_value({name, " issue_valid"}, d, issue_valid_o);
        // with the issue stage ready the decode side is acked unless the queue is full
        issue_ack_i = 1'b1;
        #1;
        check_value({name, " decoded_ack"}, in_flight < `SB_NR_ENTRIES, decoded_ack_o);
        // issue stage takes whatever is offered
        issue_ack_i = issue_valid_o;
        if (d[0]) begin
          check_value({name, " trans_id"}, next_tid, issue_trans_id_o);
          // killed entry keeps the issue pointer where it is
          if (!flush_unissued_i) begin
            slot_fu[next_tid] = fu_t'(a);
            next_tid  = (next_tid + 1) % `SB_NR_ENTRIES;
            in_flight = in_flight + 1;
          end
        end
      end
      "WB": begin
        void'($sscanf(line, "%s %d %d %h", kw, a, b, d));
        wb_valid_i[a]    = 1'b1;
        wb_trans_id_i[a] = trans_id_t'(b);
        wb_data_i[a]     = d;
      end
      "COMMIT": begin
        void'($sscanf(line, "%s %d %h", kw, a, d));
        // hold off until the head slot completes
        while (commit_valid_o !== 1'b1) begin
          step_cycle();
        end
        check_value({name, " trans_id"}, head_tid, commit_trans_id_o);
        check_value({name, " fu"}, slot_fu[head_tid], commit_fu_o);
        check_value({name, " rd"}, a, commit_rd_o);
        // unit-less instructions never produce a result
        if (slot_fu[head_tid] != NONE) begin
          check_value({name, " result"}, d, commit_result_o);
        end
        commit_ack_i = 1'b1;
        head_tid  = (head_tid + 1) % `SB_NR_ENTRIES;
        in_flight = in_flight - 1;
      end
      "READ": begin
        void'($sscanf(line, "%s %d %d %h", kw, a, b, d));
        rs1_addr_i = reg_addr_t'(a);
        rs2_addr_i = reg_addr_t'(a);
        #1;
        check_value({name, " rs1_valid"}, b, rs1_valid_o);
        check_value({name, " rs2_valid"}, b, rs2_valid_o);
        if (b != 0) begin
          check_value({name, " rs1_data"}, d, rs1_data_o);
          check_value({name, " rs2_data"}, d, rs2_data_o);
        end
      end
      "CLOB": begin
        void'($sscanf(line, "%s %d %d", kw, a, b));
        #1;
        check_value({name, " clobber"}, b, rd_clobber_o[a]);
      end
      "FULL": begin
        void'($sscanf(line, "%s %d", kw, b));
        #1;
        check_value({name, " full"}, b, sb_full_o);
      end
      "CVALID": begin
        void'($sscanf(line, "%s %d", kw, b));
        #1;
        check_value({name, " commit_valid"}, b, commit_valid_o);
      end
      "FLUSH": begin
        flush_i   = 1'b1;
        next_tid  = 0;
        head_tid  = 0;
        in_flight = 0;
      end
      "BRANCH": unresolved_branch_i = 1'b1;
      "KILL":   flush_unissued_i = 1'b1;
      "IDLE":   step_cycle();
      default:  abort_run($sformatf("unknown script command %s at %0d", kw, idx));
    endcase
  endtask

  // ----------------------------------------------------------------------
  // main sequence
  // ----------------------------------------------------------------------
  initial begin
    clk_i      = 1'b0;
    rst_ni     = 1'b0;
    rs1_addr_i = '0;
    rs2_addr_i = '0;
    clear_pulses();
    next_tid   = 0;
    head_tid   = 0;
    in_flight  = 0;
    foreach (slot_fu[i]) begin
      slot_fu[i] = NONE;
    end
    load_script();
    if (lines_q.size() == 0) begin
      abort_run("the stimulus file holds no commands");
    end
    num_cmds = lines_q.size();
    repeat (3) @(posedge clk_i);
    #2;
    rst_ni = 1'b1;
    // empty queue straight out of reset
    check_value("reset full", 0, sb_full_o);
    check_value("reset commit_valid", 0, commit_valid_o);
    for (int r = 0; r < NR_REGS; r++) begin
      check_value($sformatf("reset clobber x%0d", r), NONE, rd_clobber_o[r]);
    end
    foreach (lines_q[i]) begin
      run_command(i, lines_q[i]);
    end
    step_cycle();
    $display("Verification passed");
    $finish;
  end

  // four cycles per command is far beyond what any command needs
  initial begin
    wait (num_cmds > 0);
    repeat (4 * num_cmds + 3) @(posedge clk_i);
    abort_run($sformatf("script never finished within %0d cycles", 4 * num_cmds + 3));
  end

endmodule
